//--- hw/div_params.svh
// divider widths and one-hot op codes
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define DIV_XLEN 64  // full register width
`define DIV_HALF 32  // word-op width

// ----------------------------------------
// one-hot op codes, bit 7 down to bit 0
// ----------------------------------------
`define DIV_OP_REM   8'b1000_0000  // signed rem, 64 bit
`define DIV_OP_REMU  8'b0100_0000  // unsigned rem, 64 bit
`define DIV_OP_REMUW 8'b0010_0000  // unsigned rem, 32 bit
`define DIV_OP_REMW  8'b0001_0000  // signed rem, 32 bit
`define DIV_OP_DIV   8'b0000_1000  // signed div, 64 bit
`define DIV_OP_DIVU  8'b0000_0100  // unsigned div, 64 bit
`define DIV_OP_DIVUW 8'b0000_0010  // unsigned div, 32 bit
`define DIV_OP_DIVW  8'b0000_0001  // signed div, 32 bit

`endif

//--- hw/div_pkg.sv
// divider word, op, counter and state types
`default_nettype none

`include "div_params.svh"

package div_pkg;

  // ----------------------------------------
  // data types
  // ----------------------------------------

  // operand and result word
  typedef logic [`DIV_XLEN-1:0] xlen_t;

  // one-hot op select
  typedef logic [7:0] div_op_t;

  // iteration counter, holds up to 64
  typedef logic [6:0] div_cnt_t;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  typedef enum logic [1:0] {
    DIV_IDLE   = 2'd0,  // waiting for a request
    DIV_BUSY   = 2'd1,  // shift-subtract loop
    DIV_FINISH = 2'd2   // result held for the consumer
  } div_state_e;

endpackage : div_pkg

`default_nettype wire

//--- hw/div_special_check.sv
// divide-by-zero and signed overflow detection with defined results
`default_nettype none

`include "div_params.svh"

module div_special_check (
  input  div_pkg::div_op_t div_op_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  output logic             special_hit_o,
  output div_pkg::xlen_t   special_result_o
);
  import div_pkg::*;

  logic  op_valid;
  logic  is_word;
  logic  is_signed;
  logic  is_rem;
  logic  dvs_zero;
  logic  ovf_d;
  logic  ovf_w;
  xlen_t dvd_sext;
  xlen_t min_neg;

  // ----------------------------------------
  // op decode
  // ----------------------------------------
  assign op_valid  = |div_op_i;
  assign is_word   = |(div_op_i & (`DIV_OP_REMUW | `DIV_OP_REMW | `DIV_OP_DIVUW | `DIV_OP_DIVW));
  assign is_signed = |(div_op_i & (`DIV_OP_REM | `DIV_OP_REMW | `DIV_OP_DIV | `DIV_OP_DIVW));
  assign is_rem    = |(div_op_i & (`DIV_OP_REM | `DIV_OP_REMU | `DIV_OP_REMUW | `DIV_OP_REMW));

  // word ops only look at the low half of the divisor
  assign dvs_zero = is_word ? (divisor_i[`DIV_HALF-1:0] == '0) : (divisor_i == '0);

  // most negative / -1
  assign ovf_d = (dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (&divisor_i);
  assign ovf_w = (dividend_i[`DIV_HALF-1:0] == {1'b1, {(`DIV_HALF-1){1'b0}}}) &&
                 (&divisor_i[`DIV_HALF-1:0]);

  assign dvd_sext = {{`DIV_HALF{dividend_i[`DIV_HALF-1]}}, dividend_i[`DIV_HALF-1:0]};

  // most negative value of the op width, already sign-extended
  assign min_neg = is_word ? {{(`DIV_HALF+1){1'b1}}, {(`DIV_HALF-1){1'b0}}}
                           : {1'b1, {(`DIV_XLEN-1){1'b0}}};

  // ----------------------------------------
  // defined results
  // ----------------------------------------
  always_comb begin
    special_hit_o    = 1'b0;
    special_result_o = '0;
    if (op_valid && dvs_zero) begin
      special_hit_o = 1'b1;
      if (is_rem) begin
        special_result_o = is_word ? dvd_sext : dividend_i;  // rem by zero keeps dividend
      end else begin
        special_result_o = '1;  // quotient all ones
      end
    end else if (op_valid && is_signed && (is_word ? ovf_w : ovf_d)) begin
      special_hit_o    = 1'b1;
      special_result_o = is_rem ? '0 : min_neg;
    end
  end

endmodule : div_special_check

`default_nettype wire

//--- hw/div_operand_prep.sv
// operand extension, absolute values, sign flags and iteration count
`default_nettype none

`include "div_params.svh"

module div_operand_prep (
  input  div_pkg::div_op_t  div_op_i,
  input  div_pkg::xlen_t    dividend_i,
  input  div_pkg::xlen_t    divisor_i,
  output div_pkg::xlen_t    abs_dividend_o,
  output div_pkg::xlen_t    abs_divisor_o,
  output logic              neg_quot_o,
  output logic              neg_rem_o,
  output div_pkg::div_cnt_t iter_cnt_o
);
  import div_pkg::*;

  logic  is_word;
  logic  is_signed;
  logic  dvd_neg;
  logic  dvs_neg;
  xlen_t dvd_ext;
  xlen_t dvs_ext;
  xlen_t dvd_abs;
  xlen_t dvs_abs;

  assign is_word   = |(div_op_i & (`DIV_OP_REMUW | `DIV_OP_REMW | `DIV_OP_DIVUW | `DIV_OP_DIVW));
  assign is_signed = |(div_op_i & (`DIV_OP_REM | `DIV_OP_REMW | `DIV_OP_DIV | `DIV_OP_DIVW));

  // ----------------------------------------
  // extend word operands
  // ----------------------------------------
  always_comb begin
    dvd_ext = dividend_i;
    dvs_ext = divisor_i;
    if (is_word) begin
      if (is_signed) begin
        dvd_ext = {{`DIV_HALF{dividend_i[`DIV_HALF-1]}}, dividend_i[`DIV_HALF-1:0]};
        dvs_ext = {{`DIV_HALF{divisor_i[`DIV_HALF-1]}}, divisor_i[`DIV_HALF-1:0]};
      end else begin
        dvd_ext = {{`DIV_HALF{1'b0}}, dividend_i[`DIV_HALF-1:0]};
        dvs_ext = {{`DIV_HALF{1'b0}}, divisor_i[`DIV_HALF-1:0]};
      end
    end
  end

  // unsigned ops never count as negative
  assign dvd_neg = is_signed & dvd_ext[`DIV_XLEN-1];
  assign dvs_neg = is_signed & dvs_ext[`DIV_XLEN-1];

  assign dvd_abs = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
  assign dvs_abs = dvs_neg ? (~dvs_ext + 1'b1) : dvs_ext;

  // ----------------------------------------
  // align for the core
  // ----------------------------------------
  // word dividend goes to the top of the low word so 32 shifts drain it
  assign abs_dividend_o = is_word ? {dvd_abs[`DIV_HALF-1:0], {`DIV_HALF{1'b0}}} : dvd_abs;
  assign abs_divisor_o  = is_word ? {{`DIV_HALF{1'b0}}, dvs_abs[`DIV_HALF-1:0]} : dvs_abs;

  assign neg_quot_o = dvd_neg ^ dvs_neg;
  assign neg_rem_o  = dvd_neg;  // remainder follows dividend

  assign iter_cnt_o = is_word ? div_cnt_t'(`DIV_HALF) : div_cnt_t'(`DIV_XLEN);

endmodule : div_operand_prep

`default_nettype wire

//--- hw/div_restoring_core.sv
// divider FSM and one-bit restoring shift-subtract datapath
`default_nettype none

`include "div_params.svh"

module div_restoring_core (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              div_valid_i,
  input  logic              result_ready_i,
  input  logic              special_hit_i,
  input  div_pkg::xlen_t    special_result_i,
  input  div_pkg::xlen_t    abs_dividend_i,
  input  div_pkg::xlen_t    abs_divisor_i,
  input  div_pkg::div_cnt_t iter_cnt_i,
  output logic              start_o,
  output logic              special_taken_o,
  output div_pkg::xlen_t    special_word_o,
  output div_pkg::xlen_t    quot_raw_o,
  output div_pkg::xlen_t    rem_raw_o,
  output logic              result_ok_o,
  output logic              div_stall_o
);
  import div_pkg::*;

  div_state_e               state_q;
  div_state_e               state_d;
  div_cnt_t                 cnt_q;
  xlen_t                    divisor_q;
  logic [2*`DIV_XLEN-1:0]   rq_q;       // {remainder, quotient}
  logic                     special_taken_q;
  xlen_t                    special_word_q;
  logic                     accept;
  logic                     step;
  logic [`DIV_XLEN:0]       partial;    // shifted remainder, one extra bit
  logic [`DIV_XLEN+1:0]     diff;
  logic                     borrow;

  assign accept = (state_q == DIV_IDLE) && div_valid_i;
  assign step   = (state_q == DIV_BUSY) && (cnt_q != '0);

  // ----------------------------------------
  // restoring step
  // ----------------------------------------
  // remainder can exceed 2^63 so keep the bit shifted out of the top
  assign partial = rq_q[2*`DIV_XLEN-1:`DIV_XLEN-1];
  assign diff    = {1'b0, partial} - {2'b00, divisor_q};
  assign borrow  = diff[`DIV_XLEN+1];

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      DIV_IDLE: begin
        if (accept) begin
          state_d = special_hit_i ? DIV_FINISH : DIV_BUSY;
        end
      end
      DIV_BUSY: begin
        if (cnt_q == '0) begin
          state_d = DIV_FINISH;  // terminal cycle
        end
      end
      DIV_FINISH: begin
        if (result_ready_i) begin
          state_d = DIV_IDLE;
        end
      end
      default: state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q         <= DIV_IDLE;
      cnt_q           <= '0;
      special_taken_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        cnt_q           <= iter_cnt_i;
        special_taken_q <= special_hit_i;
      end else if (step) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    if (accept) begin
      divisor_q      <= abs_divisor_i;
      rq_q           <= {{`DIV_XLEN{1'b0}}, abs_dividend_i};
      special_word_q <= special_result_i;
    end else if (step) begin
      rq_q[2*`DIV_XLEN-1:`DIV_XLEN] <= borrow ? partial[`DIV_XLEN-1:0] : diff[`DIV_XLEN-1:0];
      rq_q[`DIV_XLEN-1:0]           <= {rq_q[`DIV_XLEN-2:0], ~borrow};  // new quotient bit
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign start_o         = accept;
  assign special_taken_o = special_taken_q;
  assign special_word_o  = special_word_q;
  assign quot_raw_o      = rq_q[`DIV_XLEN-1:0];
  assign rem_raw_o       = rq_q[2*`DIV_XLEN-1:`DIV_XLEN];
  assign result_ok_o     = (state_q == DIV_FINISH);
  assign div_stall_o     = (accept && !special_hit_i) || (state_q == DIV_BUSY);

endmodule : div_restoring_core

`default_nettype wire

//--- hw/div_result_fix.sv
// op latch, sign correction and result select
`default_nettype none

`include "div_params.svh"

module div_result_fix (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  div_pkg::div_op_t div_op_i,
  input  logic             neg_quot_i,
  input  logic             neg_rem_i,
  input  logic             special_taken_i,
  input  div_pkg::xlen_t   special_word_i,
  input  div_pkg::xlen_t   quot_raw_i,
  input  div_pkg::xlen_t   rem_raw_i,
  input  logic             result_ok_i,
  output div_pkg::xlen_t   result_o
);
  import div_pkg::*;

  div_op_t op_q;
  logic    neg_quot_q;
  logic    neg_rem_q;
  xlen_t   quot_fix;
  xlen_t   rem_fix;
  xlen_t   fixed;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      op_q       <= '0;
      neg_quot_q <= 1'b0;
      neg_rem_q  <= 1'b0;
    end else if (start_i) begin
      op_q       <= div_op_i;
      neg_quot_q <= neg_quot_i;
      neg_rem_q  <= neg_rem_i;
    end
  end

  assign quot_fix = neg_quot_q ? (~quot_raw_i + 1'b1) : quot_raw_i;
  assign rem_fix  = neg_rem_q ? (~rem_raw_i + 1'b1) : rem_raw_i;

  // ----------------------------------------
  // select by op, word results sign-extended
  // ----------------------------------------
  always_comb begin
    case (op_q)
      `DIV_OP_DIV, `DIV_OP_DIVU:   fixed = quot_fix;
      `DIV_OP_REM, `DIV_OP_REMU:   fixed = rem_fix;
      `DIV_OP_DIVW, `DIV_OP_DIVUW: fixed = {{`DIV_HALF{quot_fix[`DIV_HALF-1]}},
                                            quot_fix[`DIV_HALF-1:0]};
      `DIV_OP_REMW, `DIV_OP_REMUW: fixed = {{`DIV_HALF{rem_fix[`DIV_HALF-1]}},
                                            rem_fix[`DIV_HALF-1:0]};
      default:                     fixed = '0;
    endcase
  end

  // zero outside FINISH
  assign result_o = !result_ok_i    ? '0 :
                    special_taken_i ? special_word_i : fixed;

endmodule : div_result_fix

`default_nettype wire

//--- hw/div_unit.sv
// divide unit top level
`default_nettype none

module div_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             div_valid_i,
  input  div_pkg::div_op_t div_op_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  input  logic             result_ready_i,
  output div_pkg::xlen_t   result_o,
  output logic             result_ok_o,
  output logic             div_stall_o
);
  import div_pkg::*;

  logic     special_hit;
  xlen_t    special_result;
  xlen_t    abs_dividend;
  xlen_t    abs_divisor;
  logic     neg_quot;
  logic     neg_rem;
  div_cnt_t iter_cnt;
  logic     start;
  logic     special_taken;
  xlen_t    special_word;
  xlen_t    quot_raw;
  xlen_t    rem_raw;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  div_special_check i_special_check (
    .div_op_i         (div_op_i),
    .dividend_i       (dividend_i),
    .divisor_i        (divisor_i),
    .special_hit_o    (special_hit),
    .special_result_o (special_result)
  );

  div_operand_prep i_operand_prep (
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .abs_dividend_o (abs_dividend),
    .abs_divisor_o  (abs_divisor),
    .neg_quot_o     (neg_quot),
    .neg_rem_o      (neg_rem),
    .iter_cnt_o     (iter_cnt)
  );

  // ----------------------------------------
  // iteration and output side
  // ----------------------------------------
  div_restoring_core i_core (
    .clk              (clk),
    .rst_n            (rst_n),
    .div_valid_i      (div_valid_i),
    .result_ready_i   (result_ready_i),
    .special_hit_i    (special_hit),
    .special_result_i (special_result),
    .abs_dividend_i   (abs_dividend),
    .abs_divisor_i    (abs_divisor),
    .iter_cnt_i       (iter_cnt),
    .start_o          (start),
    .special_taken_o  (special_taken),
    .special_word_o   (special_word),
    .quot_raw_o       (quot_raw),
    .rem_raw_o        (rem_raw),
    .result_ok_o      (result_ok_o),
    .div_stall_o      (div_stall_o)
  );

  div_result_fix i_result_fix (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start),
    .div_op_i        (div_op_i),
    .neg_quot_i      (neg_quot),
    .neg_rem_i       (neg_rem),
    .special_taken_i (special_taken),
    .special_word_i  (special_word),
    .quot_raw_i      (quot_raw),
    .rem_raw_i       (rem_raw),
    .result_ok_i     (result_ok_o),
    .result_o        (result_o)
  );

endmodule : div_unit

`default_nettype wire

//--- verif/div_unit_properties.sv
// protocol assertions on the divide unit outputs, bound to div_unit
`default_nettype none

module div_unit_properties (
  input logic           clk,
  input logic           rst_n,
  input logic           div_valid_i,
  input div_pkg::div_op_t div_op_i,
  input logic           result_ready_i,
  input div_pkg::xlen_t result_o,
  input logic           result_ok_o,
  input logic           div_stall_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic in_flight_q;  // accepted, result not yet taken
  logic idle;
  int   fail_count = 0;  // failed assertion count

  always_ff @(posedge clk) begin
    if (rst_n) begin
      in_flight_q <= 1'b0;
    end else if (!in_flight_q && div_valid_i) begin
      in_flight_q <= 1'b1;
    end else if (result_ok_o && result_ready_i) begin
      in_flight_q <= 1'b0;
    end
  end

  assign idle = !in_flight_q;

  // ----------------------------------------
  // output protocol
  // ----------------------------------------
  ok_stall_excl: assert property (@(posedge clk) disable iff (rst_n)
    !(result_ok_o && div_stall_o))
    else begin
      $error("result_ok_o and div_stall_o high in the same cycle");
      fail_count++;
    end

  result_hold: assert property (@(posedge clk) disable iff (rst_n)
    (result_ok_o && !result_ready_i) |=> (result_ok_o && $stable(result_o)))
    else begin
      $error("result changed while waiting for result_ready_i");
      fail_count++;
    end

  op_onehot: assert property (@(posedge clk) disable iff (rst_n)
    (div_valid_i && idle) |-> $onehot(div_op_i))
    else begin
      $error("div_op_i not one-hot on a request");
      fail_count++;
    end

  // outputs quiet right after a reset cycle
  reset_quiet: assert property (@(posedge clk)
    rst_n |=> (!result_ok_o && !div_stall_o))
    else begin
      $error("outputs not low after reset");
      fail_count++;
    end

endmodule : div_unit_properties

`default_nettype wire

//--- verif/div_unit_tb.sv
// testbench for div_unit with random stimulus and a RISC-V reference model
`default_nettype none

`include "div_params.svh"

module div_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import div_pkg::*;

  logic    clk;
  logic    rst_n;
  logic    div_valid;
  div_op_t div_op;
  xlen_t   dividend;
  xlen_t   divisor;
  logic    result_ready;
  xlen_t   result;
  logic    result_ok;
  logic    div_stall;

  logic [31:0] rand_state;
  int          err_count;
  int          check_count;
  int          timeout_count;

  div_unit i_div_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid),
    .div_op_i       (div_op),
    .dividend_i     (dividend),
    .divisor_i      (divisor),
    .result_ready_i (result_ready),
    .result_o       (result),
    .result_ok_o    (result_ok),
    .div_stall_o    (div_stall)
  );

  bind div_unit div_unit_properties i_div_unit_properties (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .result_ok_o    (result_ok_o),
    .div_stall_o    (div_stall_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ----------------------------------------
  // random numbers
  // ----------------------------------------
  // LCG, upper halves of two steps
  function logic [31:0] next_rand();
    logic [15:0] hi;
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    hi = rand_state[31:16];
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {hi, rand_state[31:16]};
  endfunction

  function xlen_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  // biased toward zero, -1 and most negative values
  function xlen_t pick_operand();
    logic [31:0] sel;
    sel = next_rand();
    case (sel[3:0])
      4'd0:    return {60'b0, sel[7:4]};
      4'd1:    return '0;
      4'd2:    return '1;
      4'd3:    return {1'b1, 63'b0};
      4'd4:    return {next_rand(), 32'h8000_0000};
      4'd5:    return {next_rand(), 32'h0000_0000};
      4'd6:    return {next_rand(), 32'hffff_ffff};
      4'd7:    return rand_word() >> sel[9:4];  // spread of magnitudes
      default: return rand_word();
    endcase
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic xlen_t model_result(div_op_t op, xlen_t a, xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [31:0]        ua;
    logic [31:0]        ub;
    logic [31:0]        w;
    xlen_t              r;
    bit                 word;
    sa = a;
    sb = b;
    wa = a[31:0];
    wb = b[31:0];
    ua = a[31:0];
    ub = b[31:0];
    w = '0;
    r = '0;
    word = 1'b0;
    case (op)
      `DIV_OP_DIVU: r = (b == '0) ? '1 : a / b;
      `DIV_OP_REMU: r = (b == '0) ? a : a % b;
      `DIV_OP_DIV: begin
        if (b == '0) r = '1;
        else if (sa == {1'b1, 63'b0} && sb == -1) r = a;  // overflow gives dividend
        else r = sa / sb;
      end
      `DIV_OP_REM: begin
        if (b == '0) r = a;
        else if (sa == {1'b1, 63'b0} && sb == -1) r = '0;
        else r = sa % sb;
      end
      `DIV_OP_DIVUW: begin
        word = 1'b1;
        w = (ub == '0) ? '1 : ua / ub;
      end
      `DIV_OP_REMUW: begin
        word = 1'b1;
        w = (ub == '0) ? ua : ua % ub;
      end
      `DIV_OP_DIVW: begin
        word = 1'b1;
        if (ub == '0) w = '1;
        else if (ua == 32'h8000_0000 && wb == -1) w = ua;
        else w = wa / wb;
      end
      `DIV_OP_REMW: begin
        word = 1'b1;
        if (ub == '0) w = ua;
        else if (ua == 32'h8000_0000 && wb == -1) w = '0;
        else w = wa % wb;
      end
      default: r = '0;
    endcase
    if (word) r = {{32{w[31]}}, w};  // word results always sign-extended
    return r;
  endfunction

  function automatic bit expect_special(div_op_t op, xlen_t a, xlen_t b);
    bit word;
    bit sgn;
    word = |(op & (`DIV_OP_DIVW | `DIV_OP_DIVUW | `DIV_OP_REMW | `DIV_OP_REMUW));
    sgn  = |(op & (`DIV_OP_DIV | `DIV_OP_DIVW | `DIV_OP_REM | `DIV_OP_REMW));
    if (word) begin
      return (b[31:0] == '0) || (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1);
    end
    return (b == '0) || (sgn && a == {1'b1, 63'b0} && b == '1);
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // one request, wait for the result, hold it back, then take it
  task automatic run_op(input div_op_t op, input xlen_t a, input xlen_t b, input int hold);
    xlen_t       exp_res;
    xlen_t       first;
    bit          special;
    bit          got;
    int          cycles;
    int          i;
    logic [31:0] stray;
    exp_res = model_result(op, a, b);
    special = expect_special(op, a, b);
    got = 1'b0;
    cycles = 0;
    @(posedge clk);
    #1;
    div_valid    = 1'b1;
    div_op       = op;
    dividend     = a;
    divisor      = b;
    result_ready = 1'b0;
    @(negedge clk);
    check_bit(div_stall, !special, "div_stall_o in accept cycle");
    @(posedge clk);
    #1;
    div_valid = 1'b0;
    dividend  = rand_word();  // operands are dont-care after accept
    divisor   = rand_word();
    while (!got && cycles < 100) begin
      @(negedge clk);
      cycles++;
      if (result_ok) begin
        got = 1'b1;
      end else begin
        check_bit(div_stall, 1'b1, "div_stall_o while busy");
      end
    end
    if (!got) begin
      timeout_count++;
      $display("timeout: result_ok_o did not rise within 100 cycles for op %h", op);
      return;
    end
    if (special) check_bit(cycles == 1, 1'b1, "special result one cycle after accept");
    first = result;
    check_word(first, exp_res, $sformatf("op %h a %h b %h", op, a, b));
    // back-pressure, with stray requests that must be ignored
    for (i = 0; i < hold; i++) begin
      @(posedge clk);
      #1;
      stray     = next_rand();
      div_valid = stray[0];
      div_op    = 8'b1 << stray[3:1];
      dividend  = rand_word();
      divisor   = rand_word();
      @(negedge clk);
      check_bit(result_ok, 1'b1, "result_ok_o held");
      check_word(result, first, "result_o held");
    end
    @(posedge clk);
    #1;
    div_valid    = 1'b0;
    result_ready = 1'b1;
    @(negedge clk);
    check_word(result, first, "result_o at handshake");
    @(posedge clk);
    #1;
    result_ready = 1'b0;
    @(negedge clk);
    check_bit(result_ok, 1'b0, "result_ok_o after handshake");
    check_bit(div_stall, 1'b0, "div_stall_o in idle");
    check_word(result, '0, "result_o in idle");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    div_op_t     op;
    logic [31:0] sel;
    int          k;
    int          assert_count;
    rand_state    = 32'hd50c;
    err_count     = 0;
    check_count   = 0;
    timeout_count = 0;
    rst_n         = 1'b1;  // reset is active high
    div_valid     = 1'b0;
    div_op        = '0;
    dividend      = '0;
    divisor       = '0;
    result_ready  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit(result_ok, 1'b0, "result_ok_o after reset");
      check_bit(div_stall, 1'b0, "div_stall_o after reset");
      check_word(result, '0, "result_o after reset");
    end

    // zero divisor and overflow corners for every op
    for (k = 0; k < 8; k++) begin
      op = 8'b1 << k;
      if (timeout_count == 0) run_op(op, rand_word(), '0, 0);
      if (timeout_count == 0) run_op(op, rand_word(), {next_rand(), 32'h0}, 1);
      if (timeout_count == 0) run_op(op, {1'b1, 63'b0}, '1, 2);
      if (timeout_count == 0) begin
        run_op(op, {next_rand(), 32'h8000_0000}, {next_rand(), 32'hffff_ffff}, 0);
      end
    end

    for (k = 0; k < 300; k++) begin
      sel = next_rand();
      op  = 8'b1 << sel[2:0];
      if (timeout_count == 0) begin
        run_op(op, pick_operand(), pick_operand(), int'(next_rand() % 6));
      end
    end

    assert_count = i_div_unit.i_div_unit_properties.fail_count;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             check_count, err_count, timeout_count, assert_count);
    if (err_count == 0 && timeout_count == 0 && assert_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : div_unit_tb

`default_nettype wire

//--- sources.f
+incdir+hw
hw/div_pkg.sv
hw/div_special_check.sv
hw/div_operand_prep.sv
hw/div_restoring_core.sv
hw/div_result_fix.sv
hw/div_unit.sv
verif/div_unit_properties.sv
verif/div_unit_tb.sv
